// ==== source/ps2_kbd_pkg.sv ====
package ps2_kbd_pkg;

    // ------------------------------
    // Data types
    // ------------------------------

    typedef logic [7:0] scan_code_t;     // One byte from the keyboard

    typedef logic [3:0] hex_digit_t;     // One nibble on a display digit

    // Bit 7 is the decimal point, bits 6..0 are segments g..a, lit when 0
    typedef logic [7:0] seg_pattern_t;

    // ------------------------------
    // Tracker states
    // ------------------------------

    typedef enum logic [2:0] {
        st_idle       = 3'd0,            // Waiting for a byte in the FIFO
        st_fetch      = 3'd1,            // Popping the head byte
        st_show       = 3'd2,            // New make code is on the display
        st_break_wait = 3'd3,            // Prefix seen, waiting for the code
        st_release    = 3'd4             // Popping the released key code
    } tracker_state_t;

    // ------------------------------
    // Constants
    // ------------------------------

    localparam scan_code_t break_prefix = 8'hF0;    // Starts a break sequence

    localparam seg_pattern_t seg_blank = 8'hFF;     // All segments and dot dark

endpackage

// ==== source/ps2_frame_receiver.sv ====
`timescale 1ns/1ps

module ps2_frame_receiver
#(
    parameter int FIFO_DEPTH  = 8,
    parameter int SYNC_STAGES = 3
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ps2_clk,
    input  logic                   ps2_dat,
    input  logic                   nextdata_n,
    output ps2_kbd_pkg::scan_code_t code,
    output logic                   ready,
    output logic                   overflow
);

    import ps2_kbd_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   clk_prev;
    logic                   clk_fall;

    logic [10:0]            frame;
    logic [3:0]             bit_cnt;
    logic                   frame_done;
    logic                   frame_good;

    scan_code_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic [PTR_W:0]         count_next;
    logic                   full;
    logic                   push;
    logic                   pop;
    logic                   drop;

    // ------------------------------
    // Line synchronizer
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;                          // Both lines idle high
            dat_sync <= '1;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], ps2_dat};
            clk_prev <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[SYNC_STAGES-1];

    // ------------------------------
    // Frame deserializer
    // ------------------------------

    // Bits arrive LSB first, so after eleven shifts the start bit sits in frame[0]
    always_ff @(posedge clk)
    begin
        if (clk_fall)
            frame <= {dat_sync[SYNC_STAGES-1], frame[10:1]};
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (clk_fall)
            begin
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;              // Stop bit just shifted in
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // Start low, stop high, odd parity over data and parity bit
    assign frame_good = frame_done && !frame[0] && frame[10] && (^frame[9:1]);

    // ------------------------------
    // Byte FIFO
    // ------------------------------

    assign full = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign pop  = !nextdata_n && (count != '0);
    assign push = frame_good && (!full || pop);
    assign drop = frame_good && full && !pop;     // Keyboard cannot be stalled

    always_comb
    begin
        count_next = count;
        if (push && !pop)
            count_next = count + 1'b1;
        else if (pop && !push)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            ready    <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            ready <= (count_next != '0);
            if (pop)
                overflow <= 1'b0;                    // Held until the next pop
            else if (drop)
                overflow <= 1'b1;
        end
    end

    assign code = mem[rd_ptr];

endmodule

// ==== source/scan_code_tracker.sv ====
`timescale 1ns/1ps

module scan_code_tracker
(
    input  logic                    clk,
    input  logic                    rst,
    input  ps2_kbd_pkg::scan_code_t code,
    input  logic                    ready,
    output logic                    nextdata_n,
    output ps2_kbd_pkg::scan_code_t key_code,
    output logic                    blank
);

    import ps2_kbd_pkg::*;

    tracker_state_t state;
    tracker_state_t state_next;

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (ready)
                    state_next = st_fetch;
            end
            st_fetch:
            begin
                if (code == break_prefix)
                    state_next = st_break_wait;
                else
                    state_next = st_show;
            end
            // One cycle here lets ready settle after the pop
            st_show:
                state_next = st_idle;
            st_break_wait:
            begin
                if (ready)
                    state_next = st_release;
            end
            st_release:
                state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= st_idle;
        else
            state <= state_next;
    end

    // ------------------------------
    // Display registers
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key_code <= '0;
            blank    <= 1'b1;                        // Dark until the first key
        end
        else if (state == st_fetch && code != break_prefix)
        begin
            key_code <= code;
            blank    <= 1'b0;
        end
        else if (state == st_release)
            blank <= 1'b1;                           // Key released, code kept
    end

    // Exactly one pop per fetch and one per released code
    assign nextdata_n = !(state == st_fetch || state == st_release);

endmodule

// ==== source/hex_segment_decoder.sv ====
`timescale 1ns/1ps

module hex_segment_decoder
(
    input  ps2_kbd_pkg::hex_digit_t   digit,
    input  logic                      blank,
    output ps2_kbd_pkg::seg_pattern_t seg
);

    import ps2_kbd_pkg::*;

    seg_pattern_t pattern;

    always_comb
    begin
        case (digit)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;                   // Lower case b
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;                   // Lower case d
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
    end

    assign seg = blank ? seg_blank : pattern;

endmodule

// ==== source/ps2_key_display.sv ====
`timescale 1ns/1ps

module ps2_key_display
#(
    parameter int FIFO_DEPTH  = 8,
    parameter int SYNC_STAGES = 3
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ps2_clk,
    input  logic                      ps2_dat,
    output ps2_kbd_pkg::seg_pattern_t seg1,
    output ps2_kbd_pkg::seg_pattern_t seg2
);

    import ps2_kbd_pkg::*;

    scan_code_t code;
    scan_code_t key_code;
    logic       ready;
    logic       nextdata_n;
    logic       blank;

    // ------------------------------
    // Input side and tracking
    // ------------------------------

    ps2_frame_receiver
    #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SYNC_STAGES (SYNC_STAGES)
    )
    i_receiver
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .code       (code),
        .ready      (ready),
        .overflow   ()
    );

    scan_code_tracker i_tracker
    (
        .clk        (clk),
        .rst        (rst),
        .code       (code),
        .ready      (ready),
        .nextdata_n (nextdata_n),
        .key_code   (key_code),
        .blank      (blank)
    );

    // ------------------------------
    // Display digits
    // ------------------------------

    hex_segment_decoder i_seg_low
    (
        .digit (key_code[3:0]),
        .blank (blank),
        .seg   (seg1)
    );

    hex_segment_decoder i_seg_high
    (
        .digit (key_code[7:4]),
        .blank (blank),
        .seg   (seg2)
    );

endmodule

// ==== verification/ps2_key_display_sva.sv ====
`timescale 1ns/1ps

module ps2_key_display_sva
#(
    parameter int FIFO_DEPTH = 8
)
(
    input logic                          clk,
    input logic                          rst,
    input logic                          nextdata_n,
    input logic                          ready,
    input logic                          overflow,
    input logic [$clog2(FIFO_DEPTH):0]   count
);

    localparam int cnt_w = $clog2(FIFO_DEPTH) + 1;

    // ------------------------------
    // Handshake and FIFO rules
    // ------------------------------

    property pop_only_when_ready;
        @(posedge clk) disable iff (!rst)
        !nextdata_n |-> ready;
    endproperty

    property never_overflows;
        @(posedge clk) disable iff (!rst)
        !overflow;                                   // Tracker drains faster than frames arrive
    endproperty

    property empty_means_not_ready;
        @(posedge clk) disable iff (!rst)
        (count == '0) |-> !ready;
    endproperty

    property count_in_range;
        @(posedge clk) disable iff (!rst)
        count <= cnt_w'(FIFO_DEPTH);
    endproperty

    assert property (pop_only_when_ready)
        else $error("nextdata_n went low while ready was low");
    assert property (never_overflows)
        else $error("Receiver FIFO overflowed");
    assert property (empty_means_not_ready)
        else $error("ready is high while the FIFO is empty");
    assert property (count_in_range)
        else $error("FIFO count is above its depth");

endmodule

bind ps2_frame_receiver ps2_key_display_sva
#(
    .FIFO_DEPTH (FIFO_DEPTH)
)
i_sva
(
    .clk        (clk),
    .rst        (rst),
    .nextdata_n (nextdata_n),
    .ready      (ready),
    .overflow   (overflow),
    .count      (count)
);

// ==== verification/ps2_key_display_tb.sv ====
`timescale 1ns/1ps

module ps2_key_display_tb;

    import ps2_kbd_pkg::*;

    localparam int clk_period  = 8;
    localparam int bit_cycles  = 40;                 // One PS/2 bit in system cycles
    localparam int num_frames  = 26;
    localparam int watchdog_ns = num_frames * 11 * bit_cycles * clk_period * 2;

    logic         clk;
    logic         rst;
    logic         ps2_clk;
    logic         ps2_dat;
    seg_pattern_t seg1;
    seg_pattern_t seg2;

    seg_pattern_t seg_ref [16];
    scan_code_t   last_code;
    int           errors;
    int           errors_at_start;
    int           tests_passed;
    int           tests_failed;

    ps2_key_display
    #(
        .FIFO_DEPTH  (8),
        .SYNC_STAGES (3)
    )
    i_dut
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------
    // Reference and checks
    // ------------------------------

    // Segments g..a that light up for each hex digit, active high
    function automatic logic [6:0] lit_segments(input hex_digit_t d);
        case (d)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'hA: return 7'b1110111;
            4'hB: return 7'b1111100;
            4'hC: return 7'b0111001;
            4'hD: return 7'b1011110;
            4'hE: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic scan_code_t random_make_code();
        scan_code_t c;
        do
            c = scan_code_t'($urandom);
        while (c == break_prefix);
        return c;
    endfunction

    task automatic check_seg(input string test_name, input string port,
                             input seg_pattern_t expected, input seg_pattern_t actual);
        if (actual !== expected)
        begin
            $display("** Error: %s: %s expected %h, actual %h",
                     test_name, port, expected, actual);
            errors++;
        end
    endtask

    task automatic check_display(input string test_name, input scan_code_t code,
                                 input logic dark);
        seg_pattern_t exp_low;
        seg_pattern_t exp_high;
        exp_low  = dark ? seg_blank : seg_ref[code[3:0]];
        exp_high = dark ? seg_blank : seg_ref[code[7:4]];
        @(negedge clk);                              // Outputs are settled mid cycle
        check_seg(test_name, "seg1", exp_low, seg1);
        check_seg(test_name, "seg2", exp_high, seg2);
    endtask

    task automatic finish_test(input string test_name);
        if (errors == errors_at_start)
        begin
            tests_passed++;
            $display("%s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // ------------------------------
    // PS/2 device model
    // ------------------------------

    task automatic send_frame(input scan_code_t data, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = ~^data;                             // Odd parity over data and parity bit
        if (bad_parity)
            parity = ~parity;
        bits = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            @(posedge clk);
            ps2_dat <= bits[i];
            repeat (bit_cycles / 4) @(posedge clk);
            ps2_clk <= 1'b0;                         // Receiver samples on this edge
            repeat (bit_cycles / 2) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (bit_cycles / 4 - 1) @(posedge clk);
        end
    endtask

    // Half a PS/2 bit of idle line, far longer than the receive latency
    task automatic settle();
        repeat (bit_cycles / 2) @(posedge clk);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic test_reset_state();
        errors_at_start = errors;
        check_display("reset_state", 8'h00, 1'b1);
        finish_test("reset_state");
    endtask

    task automatic test_make_codes();
        hex_digit_t high [16];
        hex_digit_t tmp;
        scan_code_t code;
        int         j;
        errors_at_start = errors;
        for (int i = 0; i < 16; i++)
            high[i] = hex_digit_t'(i);
        for (int i = 15; i > 0; i--)
        begin
            j       = $urandom_range(i, 0);
            tmp     = high[i];
            high[i] = high[j];
            high[j] = tmp;
        end
        if (high[0] == 4'hF)                         // Keeps F0 out of the make codes
        begin
            high[0] = high[1];
            high[1] = 4'hF;
        end
        for (int i = 0; i < 16; i++)
        begin
            code = {high[i], hex_digit_t'(i)};
            send_frame(code, 1'b0);
            settle();
            check_display("make_codes", code, 1'b0);
            last_code = code;
        end
        finish_test("make_codes");
    endtask

    task automatic test_break_sequence();
        scan_code_t code;
        scan_code_t next_code;
        errors_at_start = errors;
        code = random_make_code();
        send_frame(code, 1'b0);
        settle();
        check_display("break_sequence", code, 1'b0);
        send_frame(break_prefix, 1'b0);
        send_frame(code, 1'b0);
        settle();
        check_display("break_sequence", code, 1'b1);
        next_code = random_make_code();
        send_frame(next_code, 1'b0);
        settle();
        check_display("break_sequence", next_code, 1'b0);
        last_code = next_code;
        finish_test("break_sequence");
    endtask

    task automatic test_bad_parity();
        scan_code_t bad_code;
        scan_code_t good_code;
        errors_at_start = errors;
        do
            bad_code = random_make_code();
        while (bad_code == last_code);
        send_frame(bad_code, 1'b1);
        settle();
        check_display("bad_parity", last_code, 1'b0);
        good_code = random_make_code();
        send_frame(good_code, 1'b0);
        settle();
        check_display("bad_parity", good_code, 1'b0);
        last_code = good_code;
        finish_test("bad_parity");
    endtask

    task automatic test_back_to_back();
        scan_code_t code;
        errors_at_start = errors;
        for (int i = 0; i < 4; i++)
        begin
            code = random_make_code();
            send_frame(code, 1'b0);
        end
        settle();
        check_display("back_to_back", code, 1'b0);
        last_code = code;
        finish_test("back_to_back");
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------

    initial
    begin
        void'($urandom(36044));
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_code    = 8'h00;
        for (int i = 0; i < 16; i++)
            seg_ref[i] = {1'b1, ~lit_segments(hex_digit_t'(i))};   // Dot off, lit when 0
        rst     <= 1'b0;
        ps2_clk <= 1'b1;
        ps2_dat <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        test_reset_state();
        test_make_codes();
        test_break_sequence();
        test_bad_parity();
        test_back_to_back();
        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
source/ps2_kbd_pkg.sv
source/ps2_frame_receiver.sv
source/scan_code_tracker.sv
source/hex_segment_decoder.sv
source/ps2_key_display.sv
verification/ps2_key_display_sva.sv
verification/ps2_key_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the PS/2 key display testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=ps2_key_display_sim
log_file=sim.log

verilator --binary --timing --assert \
    --top-module ps2_key_display_tb \
    --Mdir "$build_dir" \
    -o "$sim_bin" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -q "^Simulation passed$" "$log_file"; then
    exit 0
else
    echo "Pass message not found in $log_file"
    exit 1
fi
